// File: verilog/eth_tx_pkg.sv
package eth_tx_pkg;

  // ******************************
  // line code constants.
  // ******************************

  // seven of these lead every frame.
  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  // start-of-frame delimiter.
  localparam logic [7:0] SFD_BYTE = 8'hD5;
  localparam int PREAMBLE_COUNT = 7;

  // crc-32 as sent on the wire with bit 0 first.
  localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
  localparam logic [31:0] CRC_POLY_REFLECTED = 32'hEDB8_8320;

  // ******************************
  // timing and widths.
  // ******************************

  // one clk cycle per manchester half.
  localparam int BIT_CYCLES = 2;
  localparam int TAIL_CYCLES = 4;
  localparam int LINK_PULSE_CYCLES = 2;

  localparam int LEN_W = 11;
  localparam int ADDR_W = 9;

  // ******************************
  // state machines.
  // ******************************

  typedef enum logic [2:0] {
    SER_IDLE,
    SER_PREAMBLE,
    SER_SFD,
    SER_PAYLOAD,
    SER_FCS
  } ser_state_t;

  typedef enum logic [1:0] {
    ENC_IDLE,
    ENC_DATA,
    ENC_TAIL,
    ENC_PULSE
  } enc_state_t;

endpackage

// File: verilog/tx_byte_if.sv
`timescale 1ns/1ps

// payload bytes from the loader to the serializer.
interface tx_byte_if;

  logic [7:0] byte_data;
  logic       byte_valid;
  // high with the final payload byte.
  logic       byte_last;
  // one-cycle pull of the presented byte.
  logic       take;

  modport loader (
    output byte_data,
    output byte_valid,
    output byte_last,
    input  take
  );

  modport serializer (
    input  byte_data,
    input  byte_valid,
    input  byte_last,
    output take
  );

endinterface

// File: verilog/crc_if.sv
`timescale 1ns/1ps

// control of the running crc, and its value back.
interface crc_if;

  logic        init;
  logic        bit_en;
  logic        data_bit;
  logic [31:0] crc;

  modport gen (
    input  init,
    input  bit_en,
    input  data_bit,
    output crc
  );

  modport user (
    output init,
    output bit_en,
    output data_bit,
    input  crc
  );

endinterface

// File: verilog/frame_loader.sv
`timescale 1ns/1ps

module frame_loader (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          start,
  input  logic [eth_tx_pkg::LEN_W-1:0]  frame_len,
  input  logic [31:0]                   rd_data,
  output logic [eth_tx_pkg::ADDR_W-1:0] rd_addr,
  output logic                          rd_en,
  input  logic                          abort,
  tx_byte_if.loader                     bytes
);
  import eth_tx_pkg::*;

  logic              active;
  logic [LEN_W-1:0]  len;
  logic [LEN_W-1:0]  sent;
  logic [LEN_W:0]    len_round;
  logic [LEN_W-2:0]  words_left;
  logic [ADDR_W-1:0] addr;
  logic [31:0]       cur_word;
  logic [31:0]       next_word;
  logic              cur_ok;
  logic              next_ok;
  logic              fetch_q;
  logic [1:0]        byte_sel;
  logic              word_used;
  logic              issue;

  // words to fetch with the length rounded up.
  assign len_round = {1'b0, frame_len} + (LEN_W + 1)'(3);
  assign word_used = bytes.take && (byte_sel == 2'd3);
  // one read in flight at a time, and only into a free slot.
  assign issue = active && !rd_en && !fetch_q && (words_left != '0) && !(cur_ok && next_ok);

  assign rd_addr = addr;
  // byte 0 sits in the top bits of the word.
  assign bytes.byte_data  = cur_word[8 * (3 - byte_sel) +: 8];
  assign bytes.byte_valid = active && cur_ok;
  assign bytes.byte_last  = (sent == len - 1'b1);

  always_ff @(posedge CLK)
  begin
    if (!RST || abort)
    begin
      active     <= 1'b0;
      rd_en      <= 1'b0;
      fetch_q    <= 1'b0;
      cur_ok     <= 1'b0;
      next_ok    <= 1'b0;
      byte_sel   <= 2'd0;
      sent       <= '0;
      words_left <= '0;
      addr       <= '0;
    end
    else if (!active)
    begin
      rd_en   <= 1'b0;
      fetch_q <= 1'b0;
      if (start)
      begin
        active     <= 1'b1;
        len        <= frame_len;
        sent       <= '0;
        addr       <= '0;
        words_left <= len_round[LEN_W:2];
        rd_en      <= (frame_len != '0);
        cur_ok     <= 1'b0;
        next_ok    <= 1'b0;
        byte_sel   <= 2'd0;
      end
    end
    else
    begin
      rd_en   <= issue;
      fetch_q <= rd_en;
      if (rd_en)
      begin
        addr       <= addr + 1'b1;
        words_left <= words_left - 1'b1;
      end

      if (bytes.take)
      begin
        sent     <= sent + 1'b1;
        byte_sel <= byte_sel + 2'd1;
      end

      // move next into current when a word runs out, then land any read.
      if (word_used)
      begin
        cur_word <= next_word;
        cur_ok   <= next_ok;
        next_ok  <= 1'b0;
        if (fetch_q && next_ok)
        begin
          next_word <= rd_data;
          next_ok   <= 1'b1;
        end
        else if (fetch_q)
        begin
          cur_word <= rd_data;
          cur_ok   <= 1'b1;
        end
      end
      else if (fetch_q && !cur_ok)
      begin
        cur_word <= rd_data;
        cur_ok   <= 1'b1;
      end
      else if (fetch_q)
      begin
        next_word <= rd_data;
        next_ok   <= 1'b1;
      end

      if (bytes.take && bytes.byte_last)
      begin
        active <= 1'b0;
        rd_en  <= 1'b0;
      end
    end
  end

  a_no_read_idle : assert property (@(posedge CLK) disable iff (!RST) rd_en |-> active);
  a_take_valid : assert property (@(posedge CLK) disable iff (!RST)
    bytes.take |-> bytes.byte_valid);

endmodule

// File: verilog/crc32_serial.sv
`timescale 1ns/1ps

module crc32_serial (
  input  logic CLK,
  input  logic RST,
  crc_if.gen   crc
);
  import eth_tx_pkg::*;

  logic [31:0] crc_q;
  logic        feedback;

  // low bit against the incoming bit decides the polynomial xor.
  assign feedback = crc_q[0] ^ crc.data_bit;
  assign crc.crc  = crc_q;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      crc_q <= CRC_INIT;
    end
    else if (crc.init)
    begin
      crc_q <= CRC_INIT;
    end
    else if (crc.bit_en)
    begin
      if (feedback)
      begin
        crc_q <= (crc_q >> 1) ^ CRC_POLY_REFLECTED;
      end
      else
      begin
        crc_q <= crc_q >> 1;
      end
    end
  end

  // a frame never starts while a payload bit is being folded in.
  a_init_step : assert property (@(posedge CLK) disable iff (!RST)
    !(crc.init && crc.bit_en));

endmodule

// File: verilog/frame_serializer.sv
`timescale 1ns/1ps

module frame_serializer (
  input  logic          CLK,
  input  logic          RST,
  input  logic          start,
  input  logic          abort,
  tx_byte_if.serializer bytes,
  crc_if.user           crc,
  output logic          bit_valid,
  output logic          bit_data,
  output logic          frame_end
);
  import eth_tx_pkg::*;

  ser_state_t                    state;
  logic [$clog2(BIT_CYCLES)-1:0] phase;
  logic [31:0]                   shreg;
  logic [5:0]                    bit_cnt;
  logic [2:0]                    pre_cnt;
  logic                          last_byte;
  logic                          fcs_load;
  logic                          draining;
  logic                          bit_slot;
  logic                          unit_done;

  // one bit per period, none while waiting out the encoder tail.
  assign bit_slot  = (state != SER_IDLE) && (phase == '0) && !draining;
  assign unit_done = bit_slot && (bit_cnt == 6'd1);

  assign bit_valid = bit_slot;
  assign bit_data  = shreg[0];
  assign frame_end = unit_done && (state == SER_FCS);

  assign bytes.take   = unit_done && ((state == SER_SFD) ||
                                      (state == SER_PAYLOAD && !last_byte));
  assign crc.init     = (state == SER_IDLE) && start;
  assign crc.bit_en   = bit_slot && (state == SER_PAYLOAD);
  assign crc.data_bit = shreg[0];

  always_ff @(posedge CLK)
  begin
    if (!RST || abort)
    begin
      state     <= SER_IDLE;
      phase     <= '0;
      bit_cnt   <= '0;
      pre_cnt   <= '0;
      last_byte <= 1'b0;
      fcs_load  <= 1'b0;
      draining  <= 1'b0;
    end
    else
    begin
      if (state != SER_IDLE)
      begin
        phase <= (phase == BIT_CYCLES - 1) ? '0 : phase + 1'b1;
      end
      // plain shift; the unit boundaries below override it.
      if (bit_slot)
      begin
        shreg   <= shreg >> 1;
        bit_cnt <= bit_cnt - 6'd1;
      end

      case (state)
        SER_IDLE:
        begin
          if (start)
          begin
            state     <= SER_PREAMBLE;
            shreg     <= {24'd0, PREAMBLE_BYTE};
            bit_cnt   <= 6'd8;
            pre_cnt   <= '0;
            phase     <= '0;
            last_byte <= 1'b0;
            draining  <= 1'b0;
          end
        end
        SER_PREAMBLE:
        begin
          if (unit_done)
          begin
            bit_cnt <= 6'd8;
            if (pre_cnt == PREAMBLE_COUNT - 1)
            begin
              state <= SER_SFD;
              shreg <= {24'd0, SFD_BYTE};
            end
            else
            begin
              pre_cnt <= pre_cnt + 3'd1;
              shreg   <= {24'd0, PREAMBLE_BYTE};
            end
          end
        end
        SER_SFD:
        begin
          if (unit_done)
          begin
            state     <= SER_PAYLOAD;
            shreg     <= {24'd0, bytes.byte_data};
            last_byte <= bytes.byte_last;
            bit_cnt   <= 6'd8;
          end
        end
        SER_PAYLOAD:
        begin
          if (unit_done && last_byte)
          begin
            // crc still takes this last bit; fetch it next cycle.
            state    <= SER_FCS;
            bit_cnt  <= 6'd32;
            fcs_load <= 1'b1;
          end
          else if (unit_done)
          begin
            shreg     <= {24'd0, bytes.byte_data};
            last_byte <= bytes.byte_last;
            bit_cnt   <= 6'd8;
          end
        end
        SER_FCS:
        begin
          if (fcs_load)
          begin
            shreg    <= ~crc.crc;
            fcs_load <= 1'b0;
          end
          else if (unit_done)
          begin
            // hold until the encoder has sent its tail.
            draining <= 1'b1;
            bit_cnt  <= 6'(BIT_CYCLES + TAIL_CYCLES - 1);
          end
          else if (draining && bit_cnt == '0)
          begin
            state    <= SER_IDLE;
            draining <= 1'b0;
          end
          else if (draining)
          begin
            bit_cnt <= bit_cnt - 6'd1;
          end
        end
        default:
        begin
          state <= SER_IDLE;
        end
      endcase
    end
  end

  a_idle_quiet : assert property (@(posedge CLK) disable iff (!RST)
    (state == SER_IDLE) |-> !bit_valid);

endmodule

// File: verilog/manchester_encoder.sv
`timescale 1ns/1ps

module manchester_encoder (
  input  logic CLK,
  input  logic RST,
  input  logic bit_valid,
  input  logic bit_data,
  input  logic frame_end,
  input  logic abort,
  input  logic link_pulse,
  output logic tx_wire,
  output logic tx_en,
  output logic done
);
  import eth_tx_pkg::*;

  enc_state_t                                         state;
  logic                                               half;
  logic                                               cur_bit;
  logic                                               last_bit;
  logic                                               abort_q;
  logic [$clog2(TAIL_CYCLES + LINK_PULSE_CYCLES)-1:0] cnt;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state    <= ENC_IDLE;
      tx_wire  <= 1'b0;
      tx_en    <= 1'b0;
      done     <= 1'b0;
      half     <= 1'b0;
      last_bit <= 1'b0;
      abort_q  <= 1'b0;
      cnt      <= '0;
    end
    else
    begin
      done    <= abort_q;
      abort_q <= 1'b0;
      if (abort)
      begin
        // line drops at once, done follows a cycle after.
        state   <= ENC_IDLE;
        tx_wire <= 1'b0;
        tx_en   <= 1'b0;
        half    <= 1'b0;
        abort_q <= 1'b1;
      end
      else
      begin
        case (state)
          ENC_IDLE:
          begin
            if (bit_valid)
            begin
              state    <= ENC_DATA;
              tx_en    <= 1'b1;
              tx_wire  <= ~bit_data;
              cur_bit  <= bit_data;
              last_bit <= frame_end;
              half     <= 1'b1;
            end
            else if (link_pulse)
            begin
              state   <= ENC_PULSE;
              tx_wire <= 1'b1;
              cnt     <= '0;
            end
          end
          ENC_DATA:
          begin
            if (half)
            begin
              // second half carries the bit itself.
              tx_wire <= cur_bit;
              half    <= 1'b0;
            end
            else if (last_bit || !bit_valid)
            begin
              state   <= ENC_TAIL;
              tx_en   <= 1'b0;
              tx_wire <= 1'b1;
              cnt     <= '0;
            end
            else
            begin
              tx_wire  <= ~bit_data;
              cur_bit  <= bit_data;
              last_bit <= frame_end;
              half     <= 1'b1;
            end
          end
          ENC_TAIL:
          begin
            if (cnt == TAIL_CYCLES - 1)
            begin
              state   <= ENC_IDLE;
              tx_wire <= 1'b0;
              done    <= 1'b1;
            end
            else
            begin
              cnt <= cnt + 1'b1;
            end
          end
          ENC_PULSE:
          begin
            if (cnt == LINK_PULSE_CYCLES - 1)
            begin
              state   <= ENC_IDLE;
              tx_wire <= 1'b0;
              done    <= 1'b1;
            end
            else
            begin
              cnt <= cnt + 1'b1;
            end
          end
          default:
          begin
            state <= ENC_IDLE;
          end
        endcase
      end
    end
  end

  a_idle_low : assert property (@(posedge CLK) disable iff (!RST)
    (state == ENC_IDLE) |-> !tx_wire);

endmodule

// File: verilog/eth_tx_top.sv
`timescale 1ns/1ps

module eth_tx_top (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          start,
  input  logic [eth_tx_pkg::LEN_W-1:0]  frame_len,
  input  logic [31:0]                   rd_data,
  output logic [eth_tx_pkg::ADDR_W-1:0] rd_addr,
  output logic                          rd_en,
  input  logic                          abort,
  input  logic                          link_pulse,
  output logic                          tx_wire,
  output logic                          tx_en,
  output logic                          done
);

  logic bit_valid;
  logic bit_data;
  logic frame_end;

  tx_byte_if byte_bus ();
  crc_if     crc_bus ();

  // the loader starts on the crc init pulse, so both begin only on an accepted start.
  frame_loader i_frame_loader (
    .CLK       (CLK),
    .RST       (RST),
    .start     (crc_bus.init),
    .frame_len (frame_len),
    .rd_data   (rd_data),
    .rd_addr   (rd_addr),
    .rd_en     (rd_en),
    .abort     (abort),
    .bytes     (byte_bus.loader)
  );

  crc32_serial i_crc32_serial (
    .CLK (CLK),
    .RST (RST),
    .crc (crc_bus.gen)
  );

  frame_serializer i_frame_serializer (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .abort     (abort),
    .bytes     (byte_bus.serializer),
    .crc       (crc_bus.user),
    .bit_valid (bit_valid),
    .bit_data  (bit_data),
    .frame_end (frame_end)
  );

  manchester_encoder i_manchester_encoder (
    .CLK        (CLK),
    .RST        (RST),
    .bit_valid  (bit_valid),
    .bit_data   (bit_data),
    .frame_end  (frame_end),
    .abort      (abort),
    .link_pulse (link_pulse),
    .tx_wire    (tx_wire),
    .tx_en      (tx_en),
    .done       (done)
  );

endmodule

// File: tests/eth_tx_tb.sv
`timescale 1ns/1ps

module eth_tx_tb;
  import eth_tx_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int SUM_LEN = 1 + 5 + 12 + 64;
  // four full frames, the aborted one, one more short frame, then slack.
  localparam int FRAME_CYCLES = BIT_CYCLES * (4 * 96 + 8 * SUM_LEN);
  localparam int WATCHDOG_CYCLES = FRAME_CYCLES + BIT_CYCLES * (2 * 96 + 8 * 17) + 600;

  logic                CLK;
  logic                RST;
  logic                start;
  logic [LEN_W-1:0]    frame_len;
  logic [31:0]         rd_data;
  logic [ADDR_W-1:0]   rd_addr;
  logic                rd_en;
  logic                abort;
  logic                link_pulse;
  logic                tx_wire;
  logic                tx_en;
  logic                done;

  logic [31:0]         mem [0:(1 << ADDR_W) - 1];
  logic                req_q;
  logic [ADDR_W-1:0]   req_addr;
  logic [7:0]          exp_bytes[$];
  logic                rx_bits[$];
  int                  frame_lens[4] = '{1, 5, 12, 64};
  int                  errors = 0;

  eth_tx_top i_eth_tx_top (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .frame_len  (frame_len),
    .rd_data    (rd_data),
    .rd_addr    (rd_addr),
    .rd_en      (rd_en),
    .abort      (abort),
    .link_pulse (link_pulse),
    .tx_wire    (tx_wire),
    .tx_en      (tx_en),
    .done       (done)
  );

  initial
  begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // the buffer answers a request seen at a rising edge on the next falling edge.
  always @(posedge CLK)
  begin
    req_q    <= rd_en;
    req_addr <= rd_addr;
  end

  always @(negedge CLK)
  begin
    if (req_q)
    begin
      rd_data <= mem[req_addr];
    end
  end

  // ******************************
  // error reporting.
  // ******************************

  task automatic fail_value(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    errors++;
    $display("FAILED time=%0t signal=%s expected=0x%0h actual=0x%0h",
             $time, name, expected, actual);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_msg(input string text);
    errors++;
    $display("error at %0t: %s", $time, text);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  a_abort_quiet : assert property (@(posedge CLK) disable iff (!RST)
    abort |=> (!tx_en && !tx_wire) ##1 done)
    else fail_msg("abort was not followed by a quiet line and then done");

  a_done_single : assert property (@(posedge CLK) disable iff (!RST) done |=> !done)
    else fail_msg("done stayed high for more than one cycle");

  // reads stay inside the words of the current frame.
  a_read_in_frame : assert property (@(posedge CLK) disable iff (!RST)
    rd_en |-> (int'(rd_addr) < (int'(frame_len) + 3) / 4))
    else fail_msg("buffer read outside the words of the frame");

  // ******************************
  // reference model.
  // ******************************

  // bytes on the wire go lsb first.
  function automatic logic [7:0] rx_byte(input int pos);
    logic [7:0] b;
    for (int j = 0; j < 8; j++)
    begin
      b[j] = rx_bits[pos + j];
    end
    return b;
  endfunction

  function automatic logic [31:0] reference_crc();
    logic [31:0] c;
    logic        fb;
    c = CRC_INIT;
    foreach (exp_bytes[i])
    begin
      for (int j = 0; j < 8; j++)
      begin
        fb = c[0] ^ exp_bytes[i][j];
        c  = c >> 1;
        if (fb)
        begin
          c = c ^ CRC_POLY_REFLECTED;
        end
      end
    end
    return c;
  endfunction

  // fresh buffer words and the bytes expected from them.
  task automatic load_buffer(input int len);
    logic [31:0] word;
    exp_bytes.delete();
    for (int w = 0; w < (len + 3) / 4; w++)
    begin
      mem[w] = $urandom;
      word   = mem[w];
      // the top byte of each word goes out first.
      for (int k = 0; k < 4; k++)
      begin
        if (exp_bytes.size() < len)
        begin
          exp_bytes.push_back(word[31:24]);
        end
        word = word << 8;
      end
    end
  endtask

  task automatic start_frame(input int len);
    @(negedge CLK);
    frame_len = LEN_W'(len);
    start     = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    while (!tx_en)
    begin
      @(negedge CLK);
    end
  endtask

  task automatic expect_idle(input int n);
    repeat (n)
    begin
      @(negedge CLK);
      assert (!tx_en && !tx_wire)
        else fail_msg("line became active while the transmitter should be idle");
    end
  endtask

  // ******************************
  // test sequences.
  // ******************************

  task automatic run_frame(input int len);
    logic        first_half;
    logic        expect_half;
    logic [7:0]  expected;
    logic [31:0] fcs;
    int          cycles;
    int          base;
    load_buffer(len);
    start_frame(len);
    rx_bits.delete();
    cycles = 0;
    // decode half-bit pairs; a second start mid-frame must change nothing.
    while (tx_en)
    begin
      start = (cycles == 101);
      if (cycles % 2 == 0)
      begin
        first_half = tx_wire;
      end
      else
      begin
        expect_half = ~first_half;
        assert (tx_wire == expect_half)
          else fail_value("tx_wire", 32'(expect_half), 32'(tx_wire));
        rx_bits.push_back(tx_wire);
      end
      cycles++;
      @(negedge CLK);
    end
    assert (cycles == BIT_CYCLES * (64 + 8 * len + 32))
      else fail_value("tx_en cycles", BIT_CYCLES * (64 + 8 * len + 32), cycles);

    for (int k = 0; k < 8; k++)
    begin
      expected = (k < PREAMBLE_COUNT) ? PREAMBLE_BYTE : SFD_BYTE;
      assert (rx_byte(8 * k) == expected)
        else fail_value("preamble byte", expected, rx_byte(8 * k));
    end
    for (int i = 0; i < len; i++)
    begin
      assert (rx_byte(64 + 8 * i) == exp_bytes[i])
        else fail_value("payload byte", exp_bytes[i], rx_byte(64 + 8 * i));
    end
    base = 64 + 8 * len;
    for (int j = 0; j < 32; j++)
    begin
      fcs[j] = rx_bits[base + j];
    end
    assert (fcs == ~reference_crc())
      else fail_value("fcs", ~reference_crc(), fcs);

    // first tail cycle now; a start here is still ignored.
    start = 1'b1;
    for (int t = 0; t < TAIL_CYCLES; t++)
    begin
      assert (tx_wire && !done)
        else fail_msg("tail was not high for the full tail length");
      @(negedge CLK);
      start = 1'b0;
    end
    assert (!tx_wire)
      else fail_value("tx_wire", 0, tx_wire);
    assert (done)
      else fail_value("done", 1, done);
    expect_idle(16);
  endtask

  task automatic run_abort(input int len, input int delay);
    load_buffer(len);
    start_frame(len);
    repeat (delay) @(negedge CLK);
    abort = 1'b1;
    @(negedge CLK);
    abort = 1'b0;
    assert (!tx_en && !tx_wire)
      else fail_msg("tx_en or tx_wire still high in the cycle after abort");
    @(negedge CLK);
    assert (done)
      else fail_value("done", 1, done);
    expect_idle(16);
  endtask

  task automatic run_link_pulse();
    int high;
    @(negedge CLK);
    link_pulse = 1'b1;
    @(negedge CLK);
    link_pulse = 1'b0;
    high = 0;
    while (tx_wire)
    begin
      assert (!tx_en && !done)
        else fail_msg("tx_en or done high during a link pulse");
      high++;
      @(negedge CLK);
    end
    assert (high == LINK_PULSE_CYCLES)
      else fail_value("link pulse cycles", LINK_PULSE_CYCLES, high);
    assert (done)
      else fail_value("done", 1, done);
    expect_idle(8);
  endtask

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    fail_msg("watchdog expired before the tests finished");
  end

  initial
  begin
    void'($urandom(35677));
    RST        = 1'b0;
    start      = 1'b0;
    frame_len  = '0;
    abort      = 1'b0;
    link_pulse = 1'b0;
    rd_data    = '0;
    for (int a = 0; a < (1 << ADDR_W); a++)
    begin
      mem[a] = $urandom;
    end

    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;
    assert (!tx_en && !tx_wire && !done && !rd_en)
      else fail_msg("outputs not low after reset");

    foreach (frame_lens[f])
    begin
      run_frame(frame_lens[f]);
    end
    run_abort(12, 60);
    run_link_pulse();
    // the transmitter must recover cleanly after the abort.
    run_frame(5);

    if (errors == 0)
    begin
      $display("ALL TESTS PASSED");
      $finish;
    end
    else
    begin
      $display("SOME TESTS FAILED");
      $fatal(1, "errors were found");
    end
  end

endmodule

// File: list.f
verilog/eth_tx_pkg.sv
verilog/tx_byte_if.sv
verilog/crc_if.sv
verilog/frame_loader.sv
verilog/crc32_serial.sv
verilog/frame_serializer.sv
verilog/manchester_encoder.sv
verilog/eth_tx_top.sv
tests/eth_tx_tb.sv
